/* Bender.yml */
package:
  name: axi_lite_isolate

sources:
  - rtl/isol_pkg.sv
  - rtl/isol_pending_cnt.sv
  - rtl/isol_ctrl.sv
  - rtl/isol_err_slave.sv
  - rtl/isol_route.sv
  - rtl/axi_lite_isolate.sv
  - target: simulation
    files:
      - sim/axi_lite_isolate_props.sv
      - sim/tb_axi_lite_isolate.sv

/* rtl/axi_lite_isolate.sv */
// dropping isolate_i while a local error response is still unaccepted strands that response
`timescale 1ns/100ps

module axi_lite_isolate import isol_pkg::*; (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              isolate_i,
  output logic              isolated_o,
  input  logic              slv_aw_valid_i,
  output logic              slv_aw_ready_o,
  input  logic [ID_W-1:0]   slv_aw_id_i,
  input  logic [ADDR_W-1:0] slv_aw_addr_i,
  input  logic              slv_w_valid_i,
  output logic              slv_w_ready_o,
  input  logic [DATA_W-1:0] slv_w_data_i,
  output logic              slv_b_valid_o,
  input  logic              slv_b_ready_i,
  output logic [ID_W-1:0]   slv_b_id_o,
  output logic [RESP_W-1:0] slv_b_resp_o,
  input  logic              slv_ar_valid_i,
  output logic              slv_ar_ready_o,
  input  logic [ID_W-1:0]   slv_ar_id_i,
  input  logic [ADDR_W-1:0] slv_ar_addr_i,
  output logic              slv_r_valid_o,
  input  logic              slv_r_ready_i,
  output logic [ID_W-1:0]   slv_r_id_o,
  output logic [DATA_W-1:0] slv_r_data_o,
  output logic [RESP_W-1:0] slv_r_resp_o,
  output logic              mst_aw_valid_o,
  input  logic              mst_aw_ready_i,
  output logic [ID_W-1:0]   mst_aw_id_o,
  output logic [ADDR_W-1:0] mst_aw_addr_o,
  output logic              mst_w_valid_o,
  input  logic              mst_w_ready_i,
  output logic [DATA_W-1:0] mst_w_data_o,
  input  logic              mst_b_valid_i,
  output logic              mst_b_ready_o,
  input  logic [ID_W-1:0]   mst_b_id_i,
  input  logic [RESP_W-1:0] mst_b_resp_i,
  output logic              mst_ar_valid_o,
  input  logic              mst_ar_ready_i,
  output logic [ID_W-1:0]   mst_ar_id_o,
  output logic [ADDR_W-1:0] mst_ar_addr_o,
  input  logic              mst_r_valid_i,
  output logic              mst_r_ready_o,
  input  logic [ID_W-1:0]   mst_r_id_i,
  input  logic [DATA_W-1:0] mst_r_data_i,
  input  logic [RESP_W-1:0] mst_r_resp_i
);

  logic              block_aw;
  logic              block_ar;
  logic              err_aw_valid;
  logic              err_aw_ready;
  logic [ID_W-1:0]   err_aw_id;
  logic              err_w_valid;
  logic              err_w_ready;
  logic              err_b_valid;
  logic              err_b_ready;
  logic [ID_W-1:0]   err_b_id;
  logic [RESP_W-1:0] err_b_resp;
  logic              err_ar_valid;
  logic              err_ar_ready;
  logic [ID_W-1:0]   err_ar_id;
  logic              err_r_valid;
  logic              err_r_ready;
  logic [ID_W-1:0]   err_r_id;
  logic [DATA_W-1:0] err_r_data;
  logic [RESP_W-1:0] err_r_resp;

  // the controller counts what actually crosses the master port after the router
  isol_ctrl isol_ctrl_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .isolate_i      (isolate_i),
    .mst_aw_valid_i (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .mst_b_valid_i  (mst_b_valid_i),
    .mst_b_ready_i  (mst_b_ready_o),
    .mst_ar_valid_i (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_ready_i  (mst_r_ready_o),
    .block_aw_o     (block_aw),
    .block_ar_o     (block_ar),
    .isolated_o     (isolated_o)
  );

  // routing to the error slave follows the registered isolated state exactly
  isol_route isol_route_i (
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_id_i    (slv_aw_id_i),
    .slv_aw_addr_i  (slv_aw_addr_i),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_data_i   (slv_w_data_i),
    .slv_b_ready_i  (slv_b_ready_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_id_i    (slv_ar_id_i),
    .slv_ar_addr_i  (slv_ar_addr_i),
    .slv_r_ready_i  (slv_r_ready_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .slv_w_ready_o  (slv_w_ready_o),
    .slv_b_valid_o  (slv_b_valid_o),
    .slv_b_id_o     (slv_b_id_o),
    .slv_b_resp_o   (slv_b_resp_o),
    .slv_ar_ready_o (slv_ar_ready_o),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_id_o     (slv_r_id_o),
    .slv_r_data_o   (slv_r_data_o),
    .slv_r_resp_o   (slv_r_resp_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .mst_w_ready_i  (mst_w_ready_i),
    .mst_b_valid_i  (mst_b_valid_i),
    .mst_b_id_i     (mst_b_id_i),
    .mst_b_resp_i   (mst_b_resp_i),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_id_i     (mst_r_id_i),
    .mst_r_data_i   (mst_r_data_i),
    .mst_r_resp_i   (mst_r_resp_i),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_id_o    (mst_aw_id_o),
    .mst_aw_addr_o  (mst_aw_addr_o),
    .mst_w_valid_o  (mst_w_valid_o),
    .mst_w_data_o   (mst_w_data_o),
    .mst_b_ready_o  (mst_b_ready_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_id_o    (mst_ar_id_o),
    .mst_ar_addr_o  (mst_ar_addr_o),
    .mst_r_ready_o  (mst_r_ready_o),
    .err_aw_ready_i (err_aw_ready),
    .err_w_ready_i  (err_w_ready),
    .err_b_valid_i  (err_b_valid),
    .err_b_id_i     (err_b_id),
    .err_b_resp_i   (err_b_resp),
    .err_ar_ready_i (err_ar_ready),
    .err_r_valid_i  (err_r_valid),
    .err_r_id_i     (err_r_id),
    .err_r_data_i   (err_r_data),
    .err_r_resp_i   (err_r_resp),
    .err_aw_valid_o (err_aw_valid),
    .err_aw_id_o    (err_aw_id),
    .err_w_valid_o  (err_w_valid),
    .err_b_ready_o  (err_b_ready),
    .err_ar_valid_o (err_ar_valid),
    .err_ar_id_o    (err_ar_id),
    .err_r_ready_o  (err_r_ready),
    .block_aw_i     (block_aw),
    .block_ar_i     (block_ar),
    .route_err_i    (isolated_o)
  );

  isol_err_slave isol_err_slave_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .err_aw_valid_i (err_aw_valid),
    .err_aw_id_i    (err_aw_id),
    .err_w_valid_i  (err_w_valid),
    .err_b_ready_i  (err_b_ready),
    .err_ar_valid_i (err_ar_valid),
    .err_ar_id_i    (err_ar_id),
    .err_r_ready_i  (err_r_ready),
    .err_aw_ready_o (err_aw_ready),
    .err_w_ready_o  (err_w_ready),
    .err_b_valid_o  (err_b_valid),
    .err_b_id_o     (err_b_id),
    .err_b_resp_o   (err_b_resp),
    .err_ar_ready_o (err_ar_ready),
    .err_r_valid_o  (err_r_valid),
    .err_r_id_o     (err_r_id),
    .err_r_data_o   (err_r_data),
    .err_r_resp_o   (err_r_resp)
  );

endmodule

/* rtl/isol_ctrl.sv */
// handshake inputs must be the router's master-side signals, so stalled addresses never count
`timescale 1ns/100ps

module isol_ctrl (
  input  logic clk_i,
  input  logic reset_i,
  input  logic isolate_i,
  input  logic mst_aw_valid_i,
  input  logic mst_aw_ready_i,
  input  logic mst_b_valid_i,
  input  logic mst_b_ready_i,
  input  logic mst_ar_valid_i,
  input  logic mst_ar_ready_i,
  input  logic mst_r_valid_i,
  input  logic mst_r_ready_i,
  output logic block_aw_o,
  output logic block_ar_o,
  output logic isolated_o
);

  logic aw_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;
  logic wr_empty;
  logic wr_full;
  logic rd_empty;
  logic rd_full;
  logic isolated_q;

  // a transfer on the master port is a cycle where valid and ready meet
  assign aw_fire = mst_aw_valid_i & mst_aw_ready_i;
  assign b_fire  = mst_b_valid_i & mst_b_ready_i;
  assign ar_fire = mst_ar_valid_i & mst_ar_ready_i;
  assign r_fire  = mst_r_valid_i & mst_r_ready_i;

  // a write stays open from its AW until its B comes back
  isol_pending_cnt wr_cnt_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .inc_i   (aw_fire),
    .dec_i   (b_fire),
    .empty_o (wr_empty),
    .full_o  (wr_full)
  );

  // a read stays open from its AR until its R comes back
  isol_pending_cnt rd_cnt_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .inc_i   (ar_fire),
    .dec_i   (r_fire),
    .empty_o (rd_empty),
    .full_o  (rd_full)
  );

  // isolation is entered only once the drain has finished in both directions,
  // and it is left on the first edge that sees the request withdrawn
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      isolated_q <= 1'b0;
    end else if (!isolate_i) begin
      isolated_q <= 1'b0;
    end else if (wr_empty && rd_empty) begin
      isolated_q <= 1'b1;
    end
  end

  // new addresses stop as soon as isolation is requested or a direction is at its limit
  assign block_aw_o = isolate_i | wr_full;
  assign block_ar_o = isolate_i | rd_full;
  assign isolated_o = isolated_q;

endmodule

/* rtl/isol_err_slave.sv */
// one write and one read in flight at most, and a pending response survives a routing change
`timescale 1ns/100ps

module isol_err_slave import isol_pkg::*; (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              err_aw_valid_i,
  input  logic [ID_W-1:0]   err_aw_id_i,
  input  logic              err_w_valid_i,
  input  logic              err_b_ready_i,
  input  logic              err_ar_valid_i,
  input  logic [ID_W-1:0]   err_ar_id_i,
  input  logic              err_r_ready_i,
  output logic              err_aw_ready_o,
  output logic              err_w_ready_o,
  output logic              err_b_valid_o,
  output logic [ID_W-1:0]   err_b_id_o,
  output logic [RESP_W-1:0] err_b_resp_o,
  output logic              err_ar_ready_o,
  output logic              err_r_valid_o,
  output logic [ID_W-1:0]   err_r_id_o,
  output logic [DATA_W-1:0] err_r_data_o,
  output logic [RESP_W-1:0] err_r_resp_o
);

  logic aw_taken_q;
  logic w_taken_q;
  logic b_valid_q;
  logic r_valid_q;
  logic aw_fire;
  logic w_fire;
  logic ar_fire;
  logic [ID_W-1:0] b_id_q;
  logic [ID_W-1:0] r_id_q;

  // each half of the write is taken once, and the taken flag stays set until B is gone
  assign err_aw_ready_o = !aw_taken_q;
  assign err_w_ready_o  = !w_taken_q;
  assign aw_fire        = err_aw_valid_i & err_aw_ready_o;
  assign w_fire         = err_w_valid_i & err_w_ready_o;

  // B goes up on the edge that completes the pair, whichever half arrives last
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_taken_q <= 1'b0;
      w_taken_q  <= 1'b0;
      b_valid_q  <= 1'b0;
    end else if (b_valid_q && err_b_ready_i) begin
      aw_taken_q <= 1'b0;
      w_taken_q  <= 1'b0;
      b_valid_q  <= 1'b0;
    end else begin
      if (aw_fire) begin
        aw_taken_q <= 1'b1;
      end
      if (w_fire) begin
        w_taken_q <= 1'b1;
      end
      if ((aw_taken_q || aw_fire) && (w_taken_q || w_fire)) begin
        b_valid_q <= 1'b1;
      end
    end
  end

  // the read answer is pending from the AR transfer until R is accepted
  assign err_ar_ready_o = !r_valid_q;
  assign ar_fire        = err_ar_valid_i & err_ar_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else if (ar_fire) begin
      r_valid_q <= 1'b1;
    end else if (err_r_ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

  // IDs are only sampled on the address transfer and are echoed back unchanged
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      b_id_q <= err_aw_id_i;
    end
    if (ar_fire) begin
      r_id_q <= err_ar_id_i;
    end
  end

  assign err_b_valid_o = b_valid_q;
  assign err_b_id_o    = b_id_q;
  assign err_b_resp_o  = RESP_SLVERR;
  assign err_r_valid_o = r_valid_q;
  assign err_r_id_o    = r_id_q;
  assign err_r_data_o  = ISOLATED_DATA;
  assign err_r_resp_o  = RESP_SLVERR;

endmodule

/* rtl/isol_pending_cnt.sv */
// never increment while full_o is high, the count does not saturate on its own
`timescale 1ns/100ps

module isol_pending_cnt import isol_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic inc_i,
  input  logic dec_i,
  output logic empty_o,
  output logic full_o
);

  // number of transactions that have been issued but not yet answered
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_d;

  // a request and a response in the same cycle cancel each other out
  always_comb begin
    count_d = count_q;
    if (inc_i && !dec_i) begin
      count_d = count_q + 1'b1;
    end else if (dec_i && !inc_i) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  // both flags look at the registered count, so an update shows one cycle later
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(NUM_PENDING));

endmodule

/* rtl/isol_pkg.sv */
// single-beat AXI4-Lite-style bus only, no bursts, atomics, strobes or user bits
package isol_pkg;

  // bus geometry of both the slave port and the master port
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ID_W   = 4;
  localparam int unsigned RESP_W = 2;

  // response codes as the bus encodes them on B and R
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

  // open transactions allowed per direction before new addresses are stalled
  localparam int unsigned NUM_PENDING = 4;

  // the counter has to reach NUM_PENDING itself, so one extra state is needed
  localparam int unsigned CNT_W = $clog2(NUM_PENDING + 1);

  // read data handed back while the master port is cut off (hexspeak for isolated)
  localparam logic [DATA_W-1:0] ISOLATED_DATA = 32'h1501A7ED;

endpackage

/* rtl/isol_route.sv */
// W is never stalled, so the downstream slave must not accept W ahead of its AW
`timescale 1ns/100ps

module isol_route import isol_pkg::*; (
  input  logic              slv_aw_valid_i,
  input  logic [ID_W-1:0]   slv_aw_id_i,
  input  logic [ADDR_W-1:0] slv_aw_addr_i,
  input  logic              slv_w_valid_i,
  input  logic [DATA_W-1:0] slv_w_data_i,
  input  logic              slv_b_ready_i,
  input  logic              slv_ar_valid_i,
  input  logic [ID_W-1:0]   slv_ar_id_i,
  input  logic [ADDR_W-1:0] slv_ar_addr_i,
  input  logic              slv_r_ready_i,
  output logic              slv_aw_ready_o,
  output logic              slv_w_ready_o,
  output logic              slv_b_valid_o,
  output logic [ID_W-1:0]   slv_b_id_o,
  output logic [RESP_W-1:0] slv_b_resp_o,
  output logic              slv_ar_ready_o,
  output logic              slv_r_valid_o,
  output logic [ID_W-1:0]   slv_r_id_o,
  output logic [DATA_W-1:0] slv_r_data_o,
  output logic [RESP_W-1:0] slv_r_resp_o,
  input  logic              mst_aw_ready_i,
  input  logic              mst_w_ready_i,
  input  logic              mst_b_valid_i,
  input  logic [ID_W-1:0]   mst_b_id_i,
  input  logic [RESP_W-1:0] mst_b_resp_i,
  input  logic              mst_ar_ready_i,
  input  logic              mst_r_valid_i,
  input  logic [ID_W-1:0]   mst_r_id_i,
  input  logic [DATA_W-1:0] mst_r_data_i,
  input  logic [RESP_W-1:0] mst_r_resp_i,
  output logic              mst_aw_valid_o,
  output logic [ID_W-1:0]   mst_aw_id_o,
  output logic [ADDR_W-1:0] mst_aw_addr_o,
  output logic              mst_w_valid_o,
  output logic [DATA_W-1:0] mst_w_data_o,
  output logic              mst_b_ready_o,
  output logic              mst_ar_valid_o,
  output logic [ID_W-1:0]   mst_ar_id_o,
  output logic [ADDR_W-1:0] mst_ar_addr_o,
  output logic              mst_r_ready_o,
  input  logic              err_aw_ready_i,
  input  logic              err_w_ready_i,
  input  logic              err_b_valid_i,
  input  logic [ID_W-1:0]   err_b_id_i,
  input  logic [RESP_W-1:0] err_b_resp_i,
  input  logic              err_ar_ready_i,
  input  logic              err_r_valid_i,
  input  logic [ID_W-1:0]   err_r_id_i,
  input  logic [DATA_W-1:0] err_r_data_i,
  input  logic [RESP_W-1:0] err_r_resp_i,
  output logic              err_aw_valid_o,
  output logic [ID_W-1:0]   err_aw_id_o,
  output logic              err_w_valid_o,
  output logic              err_b_ready_o,
  output logic              err_ar_valid_o,
  output logic [ID_W-1:0]   err_ar_id_o,
  output logic              err_r_ready_o,
  input  logic              block_aw_i,
  input  logic              block_ar_i,
  input  logic              route_err_i
);

  always_comb begin
    // whichever side is not selected sees all zeros
    mst_aw_valid_o = 1'b0;
    mst_aw_id_o    = '0;
    mst_aw_addr_o  = '0;
    mst_w_valid_o  = 1'b0;
    mst_w_data_o   = '0;
    mst_b_ready_o  = 1'b0;
    mst_ar_valid_o = 1'b0;
    mst_ar_id_o    = '0;
    mst_ar_addr_o  = '0;
    mst_r_ready_o  = 1'b0;
    err_aw_valid_o = 1'b0;
    err_aw_id_o    = '0;
    err_w_valid_o  = 1'b0;
    err_b_ready_o  = 1'b0;
    err_ar_valid_o = 1'b0;
    err_ar_id_o    = '0;
    err_r_ready_o  = 1'b0;
    if (route_err_i) begin
      // isolated, the local responder answers everything and is never stalled
      err_aw_valid_o = slv_aw_valid_i;
      err_aw_id_o    = slv_aw_id_i;
      err_w_valid_o  = slv_w_valid_i;
      err_b_ready_o  = slv_b_ready_i;
      err_ar_valid_o = slv_ar_valid_i;
      err_ar_id_o    = slv_ar_id_i;
      err_r_ready_o  = slv_r_ready_i;
      slv_aw_ready_o = err_aw_ready_i;
      slv_w_ready_o  = err_w_ready_i;
      slv_b_valid_o  = err_b_valid_i;
      slv_b_id_o     = err_b_id_i;
      slv_b_resp_o   = err_b_resp_i;
      slv_ar_ready_o = err_ar_ready_i;
      slv_r_valid_o  = err_r_valid_i;
      slv_r_id_o     = err_r_id_i;
      slv_r_data_o   = err_r_data_i;
      slv_r_resp_o   = err_r_resp_i;
    end else begin
      // a blocked address is hidden from both sides, so neither valid nor ready leaks through
      mst_aw_valid_o = slv_aw_valid_i & !block_aw_i;
      mst_aw_id_o    = slv_aw_id_i;
      mst_aw_addr_o  = slv_aw_addr_i;
      mst_w_valid_o  = slv_w_valid_i;
      mst_w_data_o   = slv_w_data_i;
      mst_b_ready_o  = slv_b_ready_i;
      mst_ar_valid_o = slv_ar_valid_i & !block_ar_i;
      mst_ar_id_o    = slv_ar_id_i;
      mst_ar_addr_o  = slv_ar_addr_i;
      mst_r_ready_o  = slv_r_ready_i;
      slv_aw_ready_o = mst_aw_ready_i & !block_aw_i;
      slv_w_ready_o  = mst_w_ready_i;
      slv_b_valid_o  = mst_b_valid_i;
      slv_b_id_o     = mst_b_id_i;
      slv_b_resp_o   = mst_b_resp_i;
      slv_ar_ready_o = mst_ar_ready_i & !block_ar_i;
      slv_r_valid_o  = mst_r_valid_i;
      slv_r_id_o     = mst_r_id_i;
      slv_r_data_o   = mst_r_data_i;
      slv_r_resp_o   = mst_r_resp_i;
    end
  end

endmodule

/* sim/axi_lite_isolate_props.sv */
// bound to every axi_lite_isolate instance, and counts its own failures for the testbench summary
`timescale 1ns/100ps

module axi_lite_isolate_props (
  input logic clk_i,
  input logic reset_i,
  input logic isolate_i,
  input logic isolated_o,
  input logic mst_aw_valid_o,
  input logic mst_w_valid_o,
  input logic mst_ar_valid_o,
  input logic slv_b_valid_o,
  input logic slv_b_ready_i,
  input logic slv_r_valid_o,
  input logic slv_r_ready_i
);

  int fail_count = 0;

  // the master port is silent for as long as the isolator holds it cut off
  assert property (@(posedge clk_i) disable iff (reset_i)
    isolated_o |-> !(mst_aw_valid_o || mst_w_valid_o || mst_ar_valid_o))
  else begin
    $error("master valid raised while isolated");
    fail_count++;
  end

  // isolation can only follow a request seen on the edge before
  assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(isolated_o) |-> $past(isolate_i))
  else begin
    $error("isolated_o rose without isolate_i");
    fail_count++;
  end

  assert property (@(posedge clk_i) reset_i |=> !isolated_o)
  else begin
    $error("isolated_o high after reset");
    fail_count++;
  end

  // responses on the slave port are not withdrawn before they are taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    slv_b_valid_o && !slv_b_ready_i |=> slv_b_valid_o)
  else begin
    $error("slave B valid dropped before ready");
    fail_count++;
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    slv_r_valid_o && !slv_r_ready_i |=> slv_r_valid_o)
  else begin
    $error("slave R valid dropped before ready");
    fail_count++;
  end

endmodule

bind axi_lite_isolate axi_lite_isolate_props props_i (.*);

/* sim/tb_axi_lite_isolate.sv */
// the memory model answers in order and expects every W in the same cycle as its AW
`timescale 1ns/100ps

module tb_axi_lite_isolate import isol_pkg::*; ();

  // forty transactions of at most twelve cycles each, plus reset and settling time
  localparam int TIMEOUT_CYCLES = 40 * 12 + 200;

  logic              clk_i = 1'b0;
  logic              reset_i;
  logic              isolate_i;
  logic              isolated_o;
  logic              slv_aw_valid_i;
  logic              slv_aw_ready_o;
  logic [ID_W-1:0]   slv_aw_id_i;
  logic [ADDR_W-1:0] slv_aw_addr_i;
  logic              slv_w_valid_i;
  logic              slv_w_ready_o;
  logic [DATA_W-1:0] slv_w_data_i;
  logic              slv_b_valid_o;
  logic              slv_b_ready_i;
  logic [ID_W-1:0]   slv_b_id_o;
  logic [RESP_W-1:0] slv_b_resp_o;
  logic              slv_ar_valid_i;
  logic              slv_ar_ready_o;
  logic [ID_W-1:0]   slv_ar_id_i;
  logic [ADDR_W-1:0] slv_ar_addr_i;
  logic              slv_r_valid_o;
  logic              slv_r_ready_i;
  logic [ID_W-1:0]   slv_r_id_o;
  logic [DATA_W-1:0] slv_r_data_o;
  logic [RESP_W-1:0] slv_r_resp_o;
  logic              mst_aw_valid_o;
  logic              mst_aw_ready_i;
  logic [ID_W-1:0]   mst_aw_id_o;
  logic [ADDR_W-1:0] mst_aw_addr_o;
  logic              mst_w_valid_o;
  logic              mst_w_ready_i;
  logic [DATA_W-1:0] mst_w_data_o;
  logic              mst_b_valid_i;
  logic              mst_b_ready_o;
  logic [ID_W-1:0]   mst_b_id_i;
  logic [RESP_W-1:0] mst_b_resp_i;
  logic              mst_ar_valid_o;
  logic              mst_ar_ready_i;
  logic [ID_W-1:0]   mst_ar_id_o;
  logic [ADDR_W-1:0] mst_ar_addr_o;
  logic              mst_r_valid_i;
  logic              mst_r_ready_o;
  logic [ID_W-1:0]   mst_r_id_i;
  logic [DATA_W-1:0] mst_r_data_i;
  logic [RESP_W-1:0] mst_r_resp_i;

  logic [31:0] lfsr_q = 32'h7bfd;
  int errors = 0;
  int cycles = 0;
  logic hold_rsp = 1'b0;
  logic [DATA_W-1:0] mem [16];
  logic [DATA_W-1:0] exp_mem [16];
  logic [ID_W+DATA_W-1:0] rd_q [$];
  logic [ID_W-1:0] wr_q [$];
  int rd_wait = 0;
  int wr_wait = 0;
  // expected responses in the order the slave port must return them
  logic [ID_W+RESP_W-1:0] exp_b [$];
  logic [ID_W+DATA_W+RESP_W-1:0] exp_r [$];

  axi_lite_isolate axi_lite_isolate_i (.*);

  always #50 clk_i = !clk_i;

  // galois LFSR, stepped once for every bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // downstream memory takes requests at once and answers each one after 0 to 7 cycles
  always @(posedge clk_i) begin
    if (reset_i) begin
      rd_q.delete();
      wr_q.delete();
      rd_wait = 0;
      wr_wait = 0;
    end else begin
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        rd_q.push_back({mst_ar_id_o, mem[mst_ar_addr_o[5:2]]});
      end
      // the data is stored on the address transfer, so W has to be there in the same cycle
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        check_val("mst_w_valid_o", mst_w_valid_o, 1);
        mem[mst_aw_addr_o[5:2]] = mst_w_data_o;
        wr_q.push_back(mst_aw_id_o);
      end
      if (mst_r_valid_i && mst_r_ready_o) begin
        void'(rd_q.pop_front());
        rd_wait = take_bits(3);
      end else if (rd_wait > 0 && rd_q.size() > 0) begin
        rd_wait--;
      end
      if (mst_b_valid_i && mst_b_ready_o) begin
        void'(wr_q.pop_front());
        wr_wait = take_bits(3);
      end else if (wr_wait > 0 && wr_q.size() > 0) begin
        wr_wait--;
      end
    end
  end

  // hold_rsp keeps new responses back but never withdraws one already shown
  always @(negedge clk_i) begin
    mst_r_valid_i <= rd_q.size() > 0 && rd_wait == 0 && (!hold_rsp || mst_r_valid_i);
    mst_b_valid_i <= wr_q.size() > 0 && wr_wait == 0 && (!hold_rsp || mst_b_valid_i);
    if (rd_q.size() > 0) begin
      {mst_r_id_i, mst_r_data_i} <= rd_q[0];
    end
    if (wr_q.size() > 0) begin
      mst_b_id_i <= wr_q[0];
    end
  end

  // upstream ready rises a cycle after valid is seen, so responses from memory wait once
  always @(negedge clk_i) begin
    slv_b_ready_i <= slv_b_valid_o;
    slv_r_ready_i <= slv_r_valid_o;
  end

  // scoreboard for every response that crosses the slave port
  always @(posedge clk_i) begin
    logic [ID_W+RESP_W-1:0] eb;
    logic [ID_W+DATA_W+RESP_W-1:0] er;
    if (!reset_i && slv_b_valid_o && slv_b_ready_i) begin
      if (exp_b.size() == 0) begin
        $display("write response arrived with no write outstanding");
        errors++;
      end else begin
        eb = exp_b.pop_front();
        check_val("slv_b_id_o", slv_b_id_o, eb[ID_W+RESP_W-1:RESP_W]);
        check_val("slv_b_resp_o", slv_b_resp_o, eb[RESP_W-1:0]);
      end
    end
    if (!reset_i && slv_r_valid_o && slv_r_ready_i) begin
      if (exp_r.size() == 0) begin
        $display("read response arrived with no read outstanding");
        errors++;
      end else begin
        er = exp_r.pop_front();
        check_val("slv_r_id_o", slv_r_id_o, er[ID_W+DATA_W+RESP_W-1:DATA_W+RESP_W]);
        check_val("slv_r_data_o", slv_r_data_o, er[DATA_W+RESP_W-1:RESP_W]);
        check_val("slv_r_resp_o", slv_r_resp_o, er[RESP_W-1:0]);
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // AW and W go out together and the task returns once the matching B has been taken
  task automatic write_txn(input logic [ID_W-1:0] id, input logic [3:0] idx,
                           input logic [DATA_W-1:0] data, input logic [RESP_W-1:0] resp);
    logic aw_done;
    logic w_done;
    exp_b.push_back({id, resp});
    @(negedge clk_i);
    slv_aw_valid_i = 1'b1;
    slv_aw_id_i    = id;
    slv_aw_addr_i  = {idx, 2'b00};
    slv_w_valid_i  = 1'b1;
    slv_w_data_i   = data;
    aw_done = 1'b0;
    w_done  = 1'b0;
    while (!(aw_done && w_done)) begin
      @(posedge clk_i);
      if (slv_aw_valid_i && slv_aw_ready_o) begin
        aw_done = 1'b1;
      end
      if (slv_w_valid_i && slv_w_ready_o) begin
        w_done = 1'b1;
      end
      @(negedge clk_i);
      if (aw_done) begin
        slv_aw_valid_i = 1'b0;
      end
      if (w_done) begin
        slv_w_valid_i = 1'b0;
      end
    end
    while (exp_b.size() > 0) begin
      @(negedge clk_i);
    end
  endtask

  task automatic start_ar(input logic [ID_W-1:0] id, input logic [3:0] idx,
                          input logic [DATA_W-1:0] data, input logic [RESP_W-1:0] resp);
    exp_r.push_back({id, data, resp});
    @(negedge clk_i);
    slv_ar_valid_i = 1'b1;
    slv_ar_id_i    = id;
    slv_ar_addr_i  = {idx, 2'b00};
  endtask

  task automatic wait_ar_accept();
    @(posedge clk_i);
    while (!slv_ar_ready_o) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    slv_ar_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_b.size() > 0 || exp_r.size() > 0) begin
      @(negedge clk_i);
    end
  endtask

  initial begin
    for (int i = 0; i < 16; i++) begin
      mem[i] = 32'hC0DE0000 | (i * 32'h0101);
    end
    reset_i        = 1'b1;
    isolate_i      = 1'b0;
    slv_aw_valid_i = 1'b0;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_w_valid_i  = 1'b0;
    slv_w_data_i   = '0;
    slv_b_ready_i  = 1'b0;
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_r_ready_i  = 1'b0;
    mst_aw_ready_i = 1'b1;
    mst_w_ready_i  = 1'b1;
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = RESP_OKAY;
    mst_ar_ready_i = 1'b1;
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = RESP_OKAY;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // pass-through, every word written is read back with its own ID
    for (int i = 0; i < 8; i++) begin
      exp_mem[i] = take_bits(32);
      write_txn(ID_W'(take_bits(4)), 4'(i), exp_mem[i], RESP_OKAY);
    end
    for (int i = 0; i < 8; i++) begin
      start_ar(ID_W'(take_bits(4)), 4'(i), exp_mem[i], RESP_OKAY);
      wait_ar_accept();
    end
    wait_idle();

    // drain, three reads held downstream while isolation is requested
    hold_rsp = 1'b1;
    for (int i = 0; i < 3; i++) begin
      start_ar(ID_W'(i + 1), 4'(i), exp_mem[i], RESP_OKAY);
      wait_ar_accept();
    end
    isolate_i = 1'b1;
    start_ar(4'h7, 4'h3, ISOLATED_DATA, RESP_SLVERR);
    repeat (4) begin
      @(posedge clk_i);
      check_val("mst_ar_valid_o", mst_ar_valid_o, 0);
      check_val("isolated_o", isolated_o, 0);
    end
    hold_rsp = 1'b0;
    // the stalled read is taken only by the local responder, after the drain
    wait_ar_accept();
    check_val("isolated_o", isolated_o, 1);
    check_val("reads still open", exp_r.size(), 1);
    wait_idle();

    // termination while isolated
    write_txn(4'h3, 4'h2, take_bits(32), RESP_SLVERR);
    start_ar(4'h5, 4'h2, ISOLATED_DATA, RESP_SLVERR);
    wait_ar_accept();
    wait_idle();

    // release, then ordinary traffic again
    isolate_i = 1'b0;
    @(negedge clk_i);
    check_val("isolated_o", isolated_o, 0);
    exp_mem[9] = take_bits(32);
    write_txn(4'h9, 4'h9, exp_mem[9], RESP_OKAY);
    start_ar(4'hA, 4'h9, exp_mem[9], RESP_OKAY);
    wait_ar_accept();
    wait_idle();

    // pending limit, the fifth read waits until one response drains
    hold_rsp = 1'b1;
    for (int i = 0; i < NUM_PENDING; i++) begin
      start_ar(ID_W'(i), 4'(i), exp_mem[i], RESP_OKAY);
      wait_ar_accept();
    end
    start_ar(4'hC, 4'h4, exp_mem[4], RESP_OKAY);
    repeat (4) begin
      @(posedge clk_i);
      check_val("mst_ar_valid_o", mst_ar_valid_o, 0);
    end
    hold_rsp = 1'b0;
    wait_ar_accept();
    wait_idle();

    repeat (4) @(negedge clk_i);
    $display("errors: %0d, assertion failures: %0d", errors,
             axi_lite_isolate_i.props_i.fail_count);
    if (errors == 0 && axi_lite_isolate_i.props_i.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
rtl/isol_pkg.sv
rtl/isol_pending_cnt.sv
rtl/isol_ctrl.sv
rtl/isol_err_slave.sv
rtl/isol_route.sv
rtl/axi_lite_isolate.sv
sim/axi_lite_isolate_props.sv
sim/tb_axi_lite_isolate.sv
